// ==== common/rv_ctl_pkg.sv ====
// ======================================================================
// shared widths and trap cause codes
// sequencer state encoding
// packed structs passed between the control blocks
// ======================================================================

`default_nettype none

package rv_ctl_pkg;

    // ==================================================================
    // widths
    // ==================================================================
    localparam int XLEN        = 32;
    localparam int PC_BITWIDTH = XLEN;
    localparam int CAUSE_BITS  = 4;

    // mcause codes, interrupt bit carried separately
    localparam logic [CAUSE_BITS-1:0] CAUSE_INSTR_MISALIGN = 4'd0;
    localparam logic [CAUSE_BITS-1:0] CAUSE_BREAKPOINT     = 4'd3;
    localparam logic [CAUSE_BITS-1:0] CAUSE_LOAD_MISALIGN  = 4'd4;
    localparam logic [CAUSE_BITS-1:0] CAUSE_TIMER_INT      = 4'd7;
    localparam logic [CAUSE_BITS-1:0] CAUSE_ECALL_M        = 4'd11;

    // ==================================================================
    // types
    // ==================================================================
    typedef enum logic [3:0] {
        S_INIT,
        S_INIT_WAIT,
        S_FETCH,
        S_DECODE,
        S_FETCH_EXE,
        S_DECODE_DATA,
        S_LOAD,
        S_LOAD_WAIT,
        S_EXCEPTION,
        S_EXCEPTION_REINIT
    } seq_state_e;

    // jal, jalr and taken branch merged by the decoder
    typedef struct packed {
        logic                   active;
        logic [PC_BITWIDTH-1:0] target;
    } jump_req_t;

    // one-cycle exception events
    typedef struct packed {
        logic ecall;
        logic ebreak;
        logic misalign;
    } exc_event_t;

    typedef struct packed {
        logic                   activate;
        logic                   is_interrupt;
        logic [CAUSE_BITS-1:0]  code;
        logic [PC_BITWIDTH-1:0] pc;
    } trap_info_t;

    // sequencer commands, each high for one cycle
    typedef struct packed {
        logic pc_init;
        logic jump_init;
        logic mret_init;
        logic trap_init;
        logic clear_exc;
        logic set_int;
        logic raise_activate;
        logic instr_misalign;
        logic load_active;
    } seq_ctl_t;

endpackage

`default_nettype wire

// ==== sequencer/ctl_sequencer.sv ====
// ======================================================================
// instruction sequencing FSM
// fetch, decode, execute and load wait, trap and redirect decisions
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module ctl_sequencer (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire                     start,
    input  rv_ctl_pkg::jump_req_t   jump,
    input  wire                     mret_active,
    input  wire                     load,
    input  wire                     load_done,
    input  rv_ctl_pkg::exc_event_t  exc,
    input  wire                     timer_triggered,
    input  wire                     fetch_init,
    input  wire                     exc_pending,
    input  wire                     int_active,
    output rv_ctl_pkg::seq_ctl_t    ctl,
    output logic                    fetch_next,
    output logic                    exe_enable,
    output logic                    data_access_enable
);

    rv_ctl_pkg::seq_state_e state;
    rv_ctl_pkg::seq_state_e state_next;

    logic first_exe;
    logic disable_access;
    logic disable_access_q;
    logic ecall_active;
    logic exc_now;

    assign exc_now = exc.ecall | exc.ebreak | exc.misalign;

    // ==================================================================
    // state and status registers
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state            <= rv_ctl_pkg::S_INIT;
            first_exe        <= 1'b0;
            disable_access_q <= 1'b0;
            ecall_active     <= 1'b0;
        end else begin
            state            <= state_next;
            disable_access_q <= disable_access;
            // nothing executed yet at the new fetch address
            if (fetch_init) begin
                first_exe <= 1'b0;
            end else if (exe_enable) begin
                first_exe <= 1'b1;
            end
            if (exc.ecall) begin
                ecall_active <= 1'b1;
            end else if (mret_active) begin
                ecall_active <= 1'b0;
            end
        end
    end

    // ==================================================================
    // next state and commands
    // ==================================================================
    always_comb begin
        state_next         = state;
        ctl                = '0;
        fetch_next         = 1'b0;
        exe_enable         = 1'b0;
        data_access_enable = 1'b0;
        disable_access     = 1'b0;

        case (state)
            rv_ctl_pkg::S_INIT: begin
                if (start) begin
                    ctl.pc_init = 1'b1;
                    state_next  = rv_ctl_pkg::S_INIT_WAIT;
                end
            end
            rv_ctl_pkg::S_INIT_WAIT: begin
                // hold while the fetch unit takes the new address
                if (!fetch_init) begin
                    state_next = rv_ctl_pkg::S_FETCH;
                end
            end
            rv_ctl_pkg::S_FETCH: begin
                state_next = rv_ctl_pkg::S_DECODE;
            end
            rv_ctl_pkg::S_DECODE: begin
                fetch_next = 1'b1;
                state_next = rv_ctl_pkg::S_FETCH_EXE;
            end
            rv_ctl_pkg::S_FETCH_EXE: begin
                data_access_enable = first_exe & ~disable_access_q;
                if (timer_triggered && !int_active && !ecall_active) begin
                    ctl.set_int = 1'b1;
                    state_next  = rv_ctl_pkg::S_EXCEPTION;
                end else if (jump.active && jump.target[1]) begin
                    ctl.instr_misalign = 1'b1;
                    state_next         = rv_ctl_pkg::S_EXCEPTION;
                end else if ((exc_now || exc_pending) && data_access_enable) begin
                    state_next = rv_ctl_pkg::S_EXCEPTION;
                end else if (jump.active || mret_active) begin
                    ctl.jump_init = jump.active;
                    ctl.mret_init = mret_active & ~jump.active;
                    state_next    = rv_ctl_pkg::S_INIT_WAIT;
                end else begin
                    state_next = rv_ctl_pkg::S_DECODE_DATA;
                end
            end
            rv_ctl_pkg::S_DECODE_DATA: begin
                exe_enable = 1'b1;
                if (load) begin
                    state_next = rv_ctl_pkg::S_LOAD;
                end else begin
                    fetch_next = 1'b1;
                    state_next = rv_ctl_pkg::S_FETCH_EXE;
                end
            end
            rv_ctl_pkg::S_LOAD: begin
                data_access_enable = 1'b1;
                ctl.load_active    = 1'b1;
                state_next         = rv_ctl_pkg::S_LOAD_WAIT;
            end
            rv_ctl_pkg::S_LOAD_WAIT: begin
                // no timeout, the memory decides
                if (exc.misalign) begin
                    state_next = rv_ctl_pkg::S_EXCEPTION;
                end else if (load_done) begin
                    fetch_next     = 1'b1;
                    disable_access = 1'b1;
                    state_next     = rv_ctl_pkg::S_FETCH_EXE;
                end
            end
            rv_ctl_pkg::S_EXCEPTION: begin
                ctl.raise_activate = 1'b1;
                state_next         = rv_ctl_pkg::S_EXCEPTION_REINIT;
            end
            rv_ctl_pkg::S_EXCEPTION_REINIT: begin
                ctl.trap_init = 1'b1;
                ctl.clear_exc = 1'b1;
                state_next    = rv_ctl_pkg::S_INIT_WAIT;
            end
            default: begin
                state_next = rv_ctl_pkg::S_INIT;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== trap/trap_capture.sv ====
// ======================================================================
// sticky exception flags and cause priority
// timer interrupt flag, trap PC and trap activate
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module trap_capture (
    input  wire                                clk,
    input  wire                                reset_n,
    input  rv_ctl_pkg::seq_ctl_t               ctl,
    input  rv_ctl_pkg::exc_event_t             exc,
    input  wire                                timer_triggered,
    input  wire [rv_ctl_pkg::PC_BITWIDTH-1:0]  pc_in,
    input  wire                                exe_enable,
    output logic                               exc_pending,
    output logic                               int_active,
    output rv_ctl_pkg::trap_info_t             trap
);

    logic ecall_q;
    logic ebreak_q;
    logic instr_mis_q;
    logic misalign_q;
    logic load_q;
    logic set_int_q;

    assign exc_pending = ecall_q | ebreak_q | instr_mis_q | misalign_q;

    // ==================================================================
    // event latches
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ecall_q     <= 1'b0;
            ebreak_q    <= 1'b0;
            instr_mis_q <= 1'b0;
            misalign_q  <= 1'b0;
            load_q      <= 1'b0;
            set_int_q   <= 1'b0;
            int_active  <= 1'b0;
        end else begin
            set_int_q <= ctl.set_int;
            if (ctl.clear_exc) begin
                ecall_q     <= 1'b0;
                ebreak_q    <= 1'b0;
                instr_mis_q <= 1'b0;
                misalign_q  <= 1'b0;
            end else begin
                ecall_q     <= ecall_q | exc.ecall;
                ebreak_q    <= ebreak_q | exc.ebreak;
                instr_mis_q <= instr_mis_q | ctl.instr_misalign;
                misalign_q  <= misalign_q | exc.misalign;
            end
            // marks a misalign as belonging to the pending load
            if (ctl.load_active) begin
                load_q <= 1'b1;
            end else if (ctl.clear_exc || exe_enable) begin
                load_q <= 1'b0;
            end
            // stays set until the timer line drops
            if (ctl.set_int) begin
                int_active <= 1'b1;
            end else if (!timer_triggered) begin
                int_active <= 1'b0;
            end
        end
    end

    // ==================================================================
    // trap info
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            trap <= '0;
        end else begin
            trap.activate     <= ctl.raise_activate;
            trap.is_interrupt <= set_int_q;
            if (exe_enable) begin
                trap.pc <= pc_in;
            end
            if (set_int_q) begin
                trap.code <= rv_ctl_pkg::CAUSE_TIMER_INT;
            end else if (ecall_q) begin
                trap.code <= rv_ctl_pkg::CAUSE_ECALL_M;
            end else if (ebreak_q) begin
                trap.code <= rv_ctl_pkg::CAUSE_BREAKPOINT;
            end else if (instr_mis_q) begin
                trap.code <= rv_ctl_pkg::CAUSE_INSTR_MISALIGN;
            end else if (misalign_q) begin
                trap.code <= load_q ? rv_ctl_pkg::CAUSE_LOAD_MISALIGN
                                    : rv_ctl_pkg::CAUSE_INSTR_MISALIGN;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_redirect.sv ====
// ======================================================================
// registered fetch start pulse
// start, jump, mret and trap vector address selection
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module fetch_redirect (
    input  wire                                 clk,
    input  wire                                 reset_n,
    input  rv_ctl_pkg::seq_ctl_t                ctl,
    input  wire [rv_ctl_pkg::PC_BITWIDTH-1:0]   start_addr,
    input  rv_ctl_pkg::jump_req_t               jump,
    input  wire [rv_ctl_pkg::PC_BITWIDTH-1:0]   mepc_in,
    input  wire [rv_ctl_pkg::PC_BITWIDTH-1:0]   mtvec_in,
    input  wire [rv_ctl_pkg::CAUSE_BITS-1:0]    code,
    output logic                                fetch_init,
    output logic [rv_ctl_pkg::PC_BITWIDTH-1:0]  fetch_start_addr
);

    logic [rv_ctl_pkg::PC_BITWIDTH-1:0] vec_base;
    logic [rv_ctl_pkg::PC_BITWIDTH-1:0] vec_offset;

    // mtvec mode sits in the low two bits
    assign vec_base   = {mtvec_in[rv_ctl_pkg::PC_BITWIDTH-1:2], 2'b00};
    assign vec_offset = {{(rv_ctl_pkg::PC_BITWIDTH - rv_ctl_pkg::CAUSE_BITS - 2){1'b0}},
                         code, 2'b00};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetch_init       <= 1'b0;
            fetch_start_addr <= '0;
        end else begin
            fetch_init <= ctl.pc_init | ctl.jump_init | ctl.mret_init | ctl.trap_init;
            if (ctl.pc_init) begin
                fetch_start_addr <= {start_addr[rv_ctl_pkg::PC_BITWIDTH-1:1], 1'b0};
            end else if (ctl.jump_init) begin
                fetch_start_addr <= {jump.target[rv_ctl_pkg::PC_BITWIDTH-1:1], 1'b0};
            end else if (ctl.mret_init) begin
                fetch_start_addr <= mepc_in;
            end else if (ctl.trap_init) begin
                // direct mode or vectored by cause
                if (mtvec_in[1:0] == 2'b00) begin
                    fetch_start_addr <= vec_base;
                end else begin
                    fetch_start_addr <= vec_base + vec_offset;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ctl_top.sv ====
// ======================================================================
// control sequencer top level
// sequencer, trap capture and fetch redirect
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module ctl_top (
    input  wire                                  clk,
    input  wire                                  reset_n,
    input  wire                                  start,
    input  wire [rv_ctl_pkg::PC_BITWIDTH-1:0]    start_addr,
    input  rv_ctl_pkg::jump_req_t                jump,
    input  wire                                  mret_active,
    input  wire                                  load,
    input  wire                                  load_done,
    input  rv_ctl_pkg::exc_event_t               exc,
    input  wire                                  timer_triggered,
    input  wire [rv_ctl_pkg::PC_BITWIDTH-1:0]    pc_in,
    input  wire [rv_ctl_pkg::PC_BITWIDTH-1:0]    mtvec_in,
    input  wire [rv_ctl_pkg::PC_BITWIDTH-1:0]    mepc_in,
    output logic                                 fetch_init,
    output logic [rv_ctl_pkg::PC_BITWIDTH-1:0]   fetch_start_addr,
    output logic                                 fetch_next,
    output logic                                 exe_enable,
    output logic                                 data_access_enable,
    output rv_ctl_pkg::trap_info_t               trap
);

    rv_ctl_pkg::seq_ctl_t ctl;
    logic                 exc_pending;
    logic                 int_active;

    ctl_sequencer u_sequencer (
        .clk                (clk),
        .reset_n            (reset_n),
        .start              (start),
        .jump               (jump),
        .mret_active        (mret_active),
        .load               (load),
        .load_done          (load_done),
        .exc                (exc),
        .timer_triggered    (timer_triggered),
        .fetch_init         (fetch_init),
        .exc_pending        (exc_pending),
        .int_active         (int_active),
        .ctl                (ctl),
        .fetch_next         (fetch_next),
        .exe_enable         (exe_enable),
        .data_access_enable (data_access_enable)
    );

    trap_capture u_trap_capture (
        .clk             (clk),
        .reset_n         (reset_n),
        .ctl             (ctl),
        .exc             (exc),
        .timer_triggered (timer_triggered),
        .pc_in           (pc_in),
        .exe_enable      (exe_enable),
        .exc_pending     (exc_pending),
        .int_active      (int_active),
        .trap            (trap)
    );

    // trap vector offset comes from the registered cause
    fetch_redirect u_fetch_redirect (
        .clk              (clk),
        .reset_n          (reset_n),
        .ctl              (ctl),
        .start_addr       (start_addr),
        .jump             (jump),
        .mepc_in          (mepc_in),
        .mtvec_in         (mtvec_in),
        .code             (trap.code),
        .fetch_init       (fetch_init),
        .fetch_start_addr (fetch_start_addr)
    );

endmodule

`default_nettype wire

// ==== sim/tb_ctl_tests.svh ====
// ======================================================================
// directed tests for the control sequencer
// start, redirects, traps, loads and the timer interrupt
// ======================================================================

task automatic test_start();
    int cycles;
    test_name = "start";
    reset_and_start();
    // fetch_exe, then decode_data with exe_enable
    wait_for("exe_enable", cycles);
    check_value(32'd2, cycles);
endtask

task automatic test_jump_mret();
    int          cycles;
    logic [31:0] target;
    test_name = "jump";
    reset_and_start();
    advance_to_fetch_exe();
    target      = next_random() & ~32'h2;
    jump.active = 1'b1;
    jump.target = target;
    wait_for("fetch_init", cycles);
    jump = '0;
    check_value(target & ~32'h1, fetch_start_addr);
    wait_for("fetch_next", cycles);
    check_value(32'd3, cycles);
    test_name = "mret";
    @(negedge clk);
    mret_active = 1'b1;
    wait_for("fetch_init", cycles);
    mret_active = 1'b0;
    check_value(mepc_in, fetch_start_addr);
endtask

task automatic test_misaligned_jump(input logic [1:0] mode);
    int cycles;
    test_name = (mode == 2'b00) ? "misaligned_jump_direct" : "misaligned_jump_vectored";
    reset_and_start();
    mtvec_in = (next_random() & ~32'h3) | {30'd0, mode};
    // an ebreak first leaves cause 3 behind
    advance_to_fetch_exe();
    exc.ebreak = 1'b1;
    @(negedge clk);
    exc = '0;
    wait_for("trap.activate", cycles);
    check_value(32'd3, 32'(trap.code));
    wait_for("fetch_init", cycles);
    pc_in = next_random() & ~32'h3;
    advance_to_fetch_exe();
    jump.active = 1'b1;
    jump.target = next_random() | 32'h2;
    @(negedge clk);
    jump = '0;
    wait_for("trap.activate", cycles);
    check_value(32'd0, 32'(trap.code));
    check_value(32'd0, 32'(trap.is_interrupt));
    check_value(pc_in, trap.pc);
    // vector offset for cause 0 is zero in both modes
    wait_for("fetch_init", cycles);
    check_value(32'd1, cycles);
    check_value(mtvec_in & ~32'h3, fetch_start_addr);
endtask

task automatic test_exception_vectored(input logic is_ebreak);
    int          cycles;
    logic [31:0] code;
    test_name = is_ebreak ? "ebreak_vectored" : "ecall_vectored";
    code      = is_ebreak ? 32'd3 : 32'd11;
    reset_and_start();
    mtvec_in = (next_random() & ~32'h3) | 32'h1;
    advance_to_fetch_exe();
    exc.ecall  = ~is_ebreak;
    exc.ebreak = is_ebreak;
    @(negedge clk);
    exc = '0;
    wait_for("trap.activate", cycles);
    check_value(code, 32'(trap.code));
    check_value(32'd0, 32'(trap.is_interrupt));
    wait_for("fetch_init", cycles);
    check_value((mtvec_in & ~32'h3) + 32'd4 * code, fetch_start_addr);
endtask

task automatic test_load();
    int cycles;
    int delay;
    test_name = "load_done";
    reset_and_start();
    load = 1'b1;
    // fetch_exe, decode_data, then the load state
    wait_for("data_access_enable", cycles);
    load = 1'b0;
    check_value(32'd3, cycles);
    activate_seen = 1'b0;
    delay         = int'(next_random() & 32'h7) + 1;
    run_cycles(delay);
    load_done = 1'b1;
    @(negedge clk);
    load_done = 1'b0;
    wait_for("fetch_next", cycles);
    check_value(32'd0, 32'(activate_seen));
    test_name = "load_misalign";
    load = 1'b1;
    wait_for("data_access_enable", cycles);
    load = 1'b0;
    @(negedge clk);
    exc.misalign = 1'b1;
    @(negedge clk);
    exc = '0;
    wait_for("trap.activate", cycles);
    check_value(32'd4, 32'(trap.code));
    check_value(32'd0, 32'(trap.is_interrupt));
endtask

task automatic test_timer();
    int          cycles;
    logic [31:0] base;
    test_name = "timer";
    reset_and_start();
    base = mtvec_in & ~32'h3;
    advance_to_fetch_exe();
    timer_triggered = 1'b1;
    wait_for("trap.activate", cycles);
    timer_triggered = 1'b0;
    check_value(32'd1, 32'(trap.is_interrupt));
    check_value(32'd7, 32'(trap.code));
    wait_for("fetch_init", cycles);
    check_value((mtvec_in[1:0] == 2'b00) ? base : base + 32'd28, fetch_start_addr);
    // ecall handler still running, timer must stay masked
    test_name = "timer_during_ecall";
    advance_to_fetch_exe();
    exc.ecall = 1'b1;
    @(negedge clk);
    exc = '0;
    wait_for("trap.activate", cycles);
    check_value(32'd11, 32'(trap.code));
    wait_for("fetch_init", cycles);
    activate_seen   = 1'b0;
    timer_triggered = 1'b1;
    run_cycles(24);
    check_value(32'd0, 32'(activate_seen));
    timer_triggered = 1'b0;
endtask

// ==== sim/tb_ctl_top.sv ====
// ======================================================================
// testbench for the control sequencer top level
// clock, reset, DUT instance, xorshift, check task and wait helpers
// ======================================================================

`timescale 1ns/1ps
`default_nettype none

module tb_ctl_top;

    logic                   clk = 1'b0;
    logic                   reset_n;
    logic                   start;
    logic [31:0]            start_addr;
    rv_ctl_pkg::jump_req_t  jump;
    logic                   mret_active;
    logic                   load;
    logic                   load_done;
    rv_ctl_pkg::exc_event_t exc;
    logic                   timer_triggered;
    logic [31:0]            pc_in;
    logic [31:0]            mtvec_in;
    logic [31:0]            mepc_in;
    logic                   fetch_init;
    logic [31:0]            fetch_start_addr;
    logic                   fetch_next;
    logic                   exe_enable;
    logic                   data_access_enable;
    rv_ctl_pkg::trap_info_t trap;

    logic [31:0] rng_state       = 32'h19b08f76;
    string       test_name       = "none";
    int          max_wait_cycles = 64;
    logic        activate_seen;

    // 100 ns period
    always #50 clk = ~clk;

    ctl_top UUT (
        .clk                (clk),
        .reset_n            (reset_n),
        .start              (start),
        .start_addr         (start_addr),
        .jump               (jump),
        .mret_active        (mret_active),
        .load               (load),
        .load_done          (load_done),
        .exc                (exc),
        .timer_triggered    (timer_triggered),
        .pc_in              (pc_in),
        .mtvec_in           (mtvec_in),
        .mepc_in            (mepc_in),
        .fetch_init         (fetch_init),
        .fetch_start_addr   (fetch_start_addr),
        .fetch_next         (fetch_next),
        .exe_enable         (exe_enable),
        .data_access_enable (data_access_enable),
        .trap               (trap)
    );

    // ==================================================================
    // helpers
    // ==================================================================
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("CHECK FAILED: test %s expected 0x%08h actual 0x%08h",
                                     test_name, expected, actual));
        end
    endtask

    // samples on falling edges, counts cycles until the strobe shows up
    task automatic wait_for(input string sig, output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            activate_seen = activate_seen | trap.activate;
            if (sig == "fetch_init")
                seen = fetch_init;
            else if (sig == "fetch_next")
                seen = fetch_next;
            else if (sig == "exe_enable")
                seen = exe_enable;
            else if (sig == "data_access_enable")
                seen = data_access_enable;
            else
                seen = trap.activate;
            if (!seen && cycles >= max_wait_cycles) begin
                report_failure($sformatf("timeout: %s never came in %0d cycles", sig, cycles));
            end
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            activate_seen = activate_seen | trap.activate;
        end
    endtask

    // ends in the falling edge after the next exe_enable
    task automatic advance_to_fetch_exe();
        int cycles;
        wait_for("exe_enable", cycles);
        @(negedge clk);
    endtask

    // reset, then start and check the first fetch_init and fetch_next
    task automatic reset_and_start();
        int cycles;
        reset_n         = 1'b0;
        start           = 1'b0;
        jump            = '0;
        mret_active     = 1'b0;
        load            = 1'b0;
        load_done       = 1'b0;
        exc             = '0;
        timer_triggered = 1'b0;
        activate_seen   = 1'b0;
        start_addr      = next_random();
        pc_in           = next_random() & ~32'h3;
        mtvec_in        = next_random();
        mepc_in         = next_random() & ~32'h3;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_value(32'd0, 32'(fetch_init));
        check_value(32'd0, 32'(trap.activate));
        start = 1'b1;
        wait_for("fetch_init", cycles);
        start = 1'b0;
        check_value(32'd1, cycles);
        check_value(start_addr & ~32'h1, fetch_start_addr);
        wait_for("fetch_next", cycles);
        check_value(32'd3, cycles);
    endtask

    `include "tb_ctl_tests.svh"

    // ==================================================================
    // test order
    // ==================================================================
    initial begin
        test_start();
        test_jump_mret();
        test_misaligned_jump(2'b00);
        test_misaligned_jump(2'b01);
        test_exception_vectored(1'b0);
        test_exception_vectored(1'b1);
        test_load();
        test_timer();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+sim
common/rv_ctl_pkg.sv
sequencer/ctl_sequencer.sv
trap/trap_capture.sv
verilog/fetch_redirect.sv
verilog/ctl_top.sv
sim/tb_ctl_top.sv

// ==== Makefile ====
# Verilator build and run of the control sequencer testbench
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_ctl_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing -j 0

.PHONY: simulate clean

# build, run, then look for the pass line in the log
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
